/* Bender.yml */
package:
  name: if_stage

export_include_dirs:
  - .

sources:
  - files:
      - fetch_pkg.sv
      - victim_if.sv
      - fetch_ctrl.sv
      - pc_pipe.sv
      - icache.sv
      - victim_cache.sv
      - if_stage.sv
  - target: test
    files:
      - tb_if_stage.sv

/* all.f */
+incdir+.
fetch_pkg.sv
victim_if.sv
fetch_ctrl.sv
pc_pipe.sv
icache.sv
victim_cache.sv
if_stage.sv
tb_if_stage.sv

/* fetch_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  enable_i,
	input  logic                  l1_hit_i,
	input  logic                  vc_hit_i,
	input  fetch_pkg::word_t      pc_i,
	input  logic                  mem_ready_i,
	output logic                  pc_en_o,
	output logic                  swap_en_o,
	output logic                  fill_en_o,
	output logic                  stall_o,
	output logic                  mem_req_o,
	output fetch_pkg::line_addr_t mem_addr_o,
	output fetch_pkg::count_t     acc_cnt_o,
	output fetch_pkg::count_t     hit_cnt_o,
	output fetch_pkg::count_t     miss_cnt_o
);

	fetch_pkg::fetch_state_e state_q, state_d;
	fetch_pkg::line_addr_t   miss_addr_q;
	fetch_pkg::count_t       acc_q, hit_q, miss_q;
	logic                    lookup_hit;
	logic                    stalled_q;

	assign lookup_hit = (state_q == fetch_pkg::ST_LOOKUP) && l1_hit_i;

	always_comb begin
		state_d = state_q;
		unique case (state_q)
			fetch_pkg::ST_LOOKUP: begin
				// victim hit is cheaper than going to memory
				if (!l1_hit_i) begin
					state_d = vc_hit_i ? fetch_pkg::ST_SWAP : fetch_pkg::ST_REFILL;
				end
			end
			fetch_pkg::ST_SWAP:   state_d = fetch_pkg::ST_LOOKUP;
			fetch_pkg::ST_REFILL: begin
				if (mem_ready_i) begin
					state_d = fetch_pkg::ST_FILL;
				end
			end
			fetch_pkg::ST_FILL:   state_d = fetch_pkg::ST_LOOKUP;
			default:              state_d = fetch_pkg::ST_LOOKUP;
		endcase
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= fetch_pkg::ST_LOOKUP;
		end else begin
			state_q <= state_d;
		end
	end

	// line address of the refill in flight
	always_ff @(posedge clk_i) begin
		if (state_q == fetch_pkg::ST_LOOKUP && !l1_hit_i && !vc_hit_i) begin
			miss_addr_q <= pc_i[31:4];
		end
	end

	// hit only when nothing stalled since the last delivery
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			stalled_q <= 1'b0;
			acc_q     <= '0;
			hit_q     <= '0;
			miss_q    <= '0;
		end else if (pc_en_o) begin
			stalled_q <= 1'b0;
			acc_q     <= acc_q + 32'd1;
			if (stalled_q) begin
				miss_q <= miss_q + 32'd1;
			end else begin
				hit_q <= hit_q + 32'd1;
			end
		end else if (stall_o) begin
			stalled_q <= 1'b1;
		end
	end

	assign pc_en_o    = lookup_hit && enable_i;
	assign stall_o    = !lookup_hit;
	assign swap_en_o  = (state_q == fetch_pkg::ST_SWAP);
	assign fill_en_o  = (state_q == fetch_pkg::ST_FILL);
	assign mem_req_o  = (state_q == fetch_pkg::ST_REFILL);
	assign mem_addr_o = miss_addr_q;
	assign acc_cnt_o  = acc_q;
	assign hit_cnt_o  = hit_q;
	assign miss_cnt_o = miss_q;

endmodule

`default_nettype wire

/* fetch_defines.svh */
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// cache geometry
// instruction words in one cache line
`define FETCH_LINE_WORDS 4

// direct-mapped L1 line count
`define FETCH_L1_LINES 16

// fully associative victim entries
`define FETCH_VC_ENTRIES 4

// first fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	// PC or instruction word
	typedef logic [31:0] word_t;

	// one cache line, word k sits at bits [k*32 +: 32]
	typedef logic [127:0] line_t;

	// PC without word and byte offset
	typedef logic [27:0] line_addr_t;

	// event counter
	typedef logic [31:0] count_t;

	// correction select from execute, same encoding as wrong_predicted
	typedef enum logic [1:0] {
		REDIR_NONE    = 2'd0,
		REDIR_MISPRED = 2'd1,
		REDIR_ALU     = 2'd2
	} redirect_e;

	// fetch control states
	typedef enum logic [1:0] {
		ST_LOOKUP = 2'd0,
		ST_SWAP   = 2'd1,
		ST_REFILL = 2'd2,
		ST_FILL   = 2'd3
	} fetch_state_e;

endpackage

`default_nettype wire

/* icache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module icache (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  fetch_pkg::word_t pc_i,
	input  logic             swap_en_i,
	input  logic             fill_en_i,
	input  fetch_pkg::line_t fill_line_i,
	output logic             hit_o,
	output fetch_pkg::word_t inst_o,
	victim_if.l1             vc
);

	localparam int unsigned IDX_W  = $clog2(`FETCH_L1_LINES);
	localparam int unsigned OFF_W  = $clog2(`FETCH_LINE_WORDS);
	localparam int unsigned LADR_W = $bits(fetch_pkg::line_addr_t);
	localparam int unsigned TAG_W  = LADR_W - IDX_W;

	fetch_pkg::line_addr_t     line_addr;
	logic [IDX_W-1:0]          idx;
	logic [TAG_W-1:0]          tag;
	logic [OFF_W-1:0]          word_sel;
	logic                      wr_en;
	fetch_pkg::line_t          new_line;
	fetch_pkg::line_t          fill_buf_q;

	logic [`FETCH_L1_LINES-1:0] valid_q;
	logic [TAG_W-1:0]           tag_q  [`FETCH_L1_LINES];
	fetch_pkg::line_t           data_q [`FETCH_L1_LINES];

	// address split: tag | index | word | byte
	assign line_addr = pc_i[31:OFF_W+2];
	assign idx       = line_addr[IDX_W-1:0];
	assign tag       = line_addr[LADR_W-1:IDX_W];
	assign word_sel  = pc_i[OFF_W+1:2];

	assign hit_o  = valid_q[idx] && (tag_q[idx] == tag);
	assign inst_o = data_q[idx][word_sel*32 +: 32];

	// memory line is only valid during the ready pulse,
	// keep it one cycle so the fill state can write it
	always_ff @(posedge clk_i) begin
		fill_buf_q <= fill_line_i;
	end

	assign wr_en    = swap_en_i || fill_en_i;
	assign new_line = swap_en_i ? vc.probe_line : fill_buf_q;

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			tag_q[idx]  <= tag;
			data_q[idx] <= new_line;
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// old line leaves for the victim cache in the write cycle
	assign vc.evict_valid = wr_en && valid_q[idx];
	assign vc.evict_addr  = {tag_q[idx], idx};
	assign vc.evict_line  = data_q[idx];
	assign vc.probe_addr  = line_addr;

endmodule

`default_nettype wire

/* if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  enable_i,
	input  logic                  flush_i,
	input  logic                  bp_hit_i,
	input  fetch_pkg::word_t      predicted_pc_i,
	input  fetch_pkg::word_t      mispredicted_pc_i,
	input  fetch_pkg::word_t      alu_pc_i,
	input  logic [1:0]            wrong_predicted_i,
	input  logic                  mem_ready_i,
	input  fetch_pkg::line_t      mem_line_i,
	output fetch_pkg::word_t      pc_d_o,
	output fetch_pkg::word_t      inst_d_o,
	output fetch_pkg::word_t      pc4_d_o,
	output logic                  hit_d_o,
	output fetch_pkg::word_t      pc_bp_o,
	output logic                  stall_o,
	output logic                  mem_req_o,
	output fetch_pkg::line_addr_t mem_addr_o,
	output fetch_pkg::count_t     acc_cnt_o,
	output fetch_pkg::count_t     hit_cnt_o,
	output fetch_pkg::count_t     miss_cnt_o
);

	fetch_pkg::word_t     pc;
	fetch_pkg::word_t     inst;
	fetch_pkg::redirect_e redirect;
	logic                 l1_hit, vc_hit;
	logic                 pc_en, swap_en, fill_en;

	victim_if vc_bus ();

	assign redirect = fetch_pkg::redirect_e'(wrong_predicted_i);
	// current PC doubles as the predictor lookup address
	assign pc_bp_o  = pc;

	fetch_ctrl i_fetch_ctrl (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.enable_i    (enable_i),
		.l1_hit_i    (l1_hit),
		.vc_hit_i    (vc_hit),
		.pc_i        (pc),
		.mem_ready_i (mem_ready_i),
		.pc_en_o     (pc_en),
		.swap_en_o   (swap_en),
		.fill_en_o   (fill_en),
		.stall_o     (stall_o),
		.mem_req_o   (mem_req_o),
		.mem_addr_o  (mem_addr_o),
		.acc_cnt_o   (acc_cnt_o),
		.hit_cnt_o   (hit_cnt_o),
		.miss_cnt_o  (miss_cnt_o)
	);

	pc_pipe i_pc_pipe (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.pc_en_i           (pc_en),
		.enable_i          (enable_i),
		.flush_i           (flush_i),
		.bp_hit_i          (bp_hit_i),
		.predicted_pc_i    (predicted_pc_i),
		.mispredicted_pc_i (mispredicted_pc_i),
		.alu_pc_i          (alu_pc_i),
		.redirect_i        (redirect),
		.inst_i            (inst),
		.pc_o              (pc),
		.pc_d_o            (pc_d_o),
		.inst_d_o          (inst_d_o),
		.pc4_d_o           (pc4_d_o),
		.hit_d_o           (hit_d_o)
	);

	icache i_icache (
		.clk_i       (clk_i),
		.rst_ni      (rst_ni),
		.pc_i        (pc),
		.swap_en_i   (swap_en),
		.fill_en_i   (fill_en),
		.fill_line_i (mem_line_i),
		.hit_o       (l1_hit),
		.inst_o      (inst),
		.vc          (vc_bus.l1)
	);

	victim_cache i_victim_cache (
		.clk_i  (clk_i),
		.rst_ni (rst_ni),
		.vc     (vc_bus.victim),
		.hit_o  (vc_hit)
	);

endmodule

`default_nettype wire

/* pc_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module pc_pipe (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  logic                 pc_en_i,
	input  logic                 enable_i,
	input  logic                 flush_i,
	input  logic                 bp_hit_i,
	input  fetch_pkg::word_t     predicted_pc_i,
	input  fetch_pkg::word_t     mispredicted_pc_i,
	input  fetch_pkg::word_t     alu_pc_i,
	input  fetch_pkg::redirect_e redirect_i,
	input  fetch_pkg::word_t     inst_i,
	output fetch_pkg::word_t     pc_o,
	output fetch_pkg::word_t     pc_d_o,
	output fetch_pkg::word_t     inst_d_o,
	output fetch_pkg::word_t     pc4_d_o,
	output logic                 hit_d_o
);

	fetch_pkg::word_t pc_q, pc4, next_pc;
	fetch_pkg::word_t pc_d_q, inst_d_q, pc4_d_q;
	logic             hit_d_q;

	assign pc4 = pc_q + 32'd4;

	// execute corrections first, then the predictor, then sequential
	always_comb begin
		unique case (redirect_i)
			fetch_pkg::REDIR_MISPRED: next_pc = mispredicted_pc_i;
			fetch_pkg::REDIR_ALU:     next_pc = alu_pc_i;
			default:                  next_pc = bp_hit_i ? predicted_pc_i : pc4;
		endcase
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			pc_q <= `FETCH_RESET_PC;
		end else if (pc_en_i) begin
			pc_q <= next_pc;
		end
	end

	// IF/ID register, flush drops the instruction in flight
	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			pc_d_q   <= '0;
			inst_d_q <= '0;
			pc4_d_q  <= '0;
			hit_d_q  <= 1'b0;
		end else if (enable_i && flush_i) begin
			pc_d_q   <= '0;
			inst_d_q <= '0;
			pc4_d_q  <= '0;
			hit_d_q  <= 1'b0;
		end else if (pc_en_i) begin
			pc_d_q   <= pc_q;
			inst_d_q <= inst_i;
			pc4_d_q  <= pc4;
			hit_d_q  <= bp_hit_i;
		end
	end

	assign pc_o     = pc_q;
	assign pc_d_o   = pc_d_q;
	assign inst_d_o = inst_d_q;
	assign pc4_d_o  = pc4_d_q;
	assign hit_d_o  = hit_d_q;

endmodule

`default_nettype wire

/* tb_if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module tb_if_stage;

	localparam logic [31:0] INST_KEY = 32'h5a5a_0000;
	localparam logic [31:0] SEED     = 32'h7f3d_6b81;

	// phases of one access, as seen from outside the DUT
	localparam int PH_LOOKUP = 0;
	localparam int PH_REFILL = 1;
	localparam int PH_FILL   = 2;
	localparam int PH_READY  = 3;
	localparam int PH_SWAP   = 4;

	localparam int MODE_SEQ      = 0;
	localparam int MODE_LOOP     = 1;
	localparam int MODE_CONFLICT = 2;
	localparam int MODE_RANDOM   = 3;

	logic                  clk_i, rst_ni, enable_i, flush_i, bp_hit_i;
	fetch_pkg::word_t      predicted_pc_i, mispredicted_pc_i, alu_pc_i;
	logic [1:0]            wrong_predicted_i;
	logic                  mem_ready_i;
	fetch_pkg::line_t      mem_line_i;
	fetch_pkg::word_t      pc_d_o, inst_d_o, pc4_d_o, pc_bp_o;
	logic                  hit_d_o, stall_o, mem_req_o;
	fetch_pkg::line_addr_t mem_addr_o;
	fetch_pkg::count_t     acc_cnt_o, hit_cnt_o, miss_cnt_o;

	// reference caches, full line address per entry
	fetch_pkg::line_addr_t l1_line  [`FETCH_L1_LINES];
	logic                  l1_valid [`FETCH_L1_LINES];
	fetch_pkg::line_addr_t vc_line  [`FETCH_VC_ENTRIES];
	logic                  vc_valid [`FETCH_VC_ENTRIES];
	int                    vc_ptr;

	fetch_pkg::word_t m_pc_bp, m_pc_d, m_inst_d, m_pc4_d;
	logic             m_hit_d, fresh, deliver;
	int               cls, phase;
	int               tally_acc, tally_hit, tally_miss, n_swap, n_refill;
	logic [31:0]      mem_rng, stim_rng;
	int               mem_wait;

	if_stage i_if_stage (
		.clk_i             (clk_i),
		.rst_ni            (rst_ni),
		.enable_i          (enable_i),
		.flush_i           (flush_i),
		.bp_hit_i          (bp_hit_i),
		.predicted_pc_i    (predicted_pc_i),
		.mispredicted_pc_i (mispredicted_pc_i),
		.alu_pc_i          (alu_pc_i),
		.wrong_predicted_i (wrong_predicted_i),
		.mem_ready_i       (mem_ready_i),
		.mem_line_i        (mem_line_i),
		.pc_d_o            (pc_d_o),
		.inst_d_o          (inst_d_o),
		.pc4_d_o           (pc4_d_o),
		.hit_d_o           (hit_d_o),
		.pc_bp_o           (pc_bp_o),
		.stall_o           (stall_o),
		.mem_req_o         (mem_req_o),
		.mem_addr_o        (mem_addr_o),
		.acc_cnt_o         (acc_cnt_o),
		.hit_cnt_o         (hit_cnt_o),
		.miss_cnt_o        (miss_cnt_o)
	);

	always #50 clk_i = ~clk_i;

	task automatic abort_run();
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
		$display("** Error: %s = 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		abort_run();
	endtask

	task automatic fail_with(input string msg);
		$display("%s at %0t", msg, $time);
		abort_run();
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// every word holds its own byte address xor the key
	function automatic fetch_pkg::line_t mem_line(input fetch_pkg::line_addr_t la);
		fetch_pkg::line_t l;
		for (int k = 0; k < `FETCH_LINE_WORDS; k++) begin
			l[k*32 +: 32] = ({la, 4'h0} + 32'(k * 4)) ^ INST_KEY;
		end
		return l;
	endfunction

	// mispredict over ALU over predictor over sequential
	function automatic fetch_pkg::word_t next_pc(input logic [1:0] wp, input logic bp,
			input fetch_pkg::word_t pc);
		if (wp == 2'd1) begin
			return mispredicted_pc_i;
		end else if (wp == 2'd2) begin
			return alu_pc_i;
		end else if (bp) begin
			return predicted_pc_i;
		end else begin
			return pc + 32'd4;
		end
	endfunction

	// 0 L1 hit, 1 victim swap, 2 refill from memory
	task automatic model_access(input fetch_pkg::line_addr_t la, output int kind);
		int idx;
		int hit_at;
		idx = int'(la % `FETCH_L1_LINES);
		hit_at = -1;
		if (l1_valid[idx] && l1_line[idx] == la) begin
			kind = 0;
		end else begin
			for (int i = 0; i < `FETCH_VC_ENTRIES; i++) begin
				if (vc_valid[i] && vc_line[i] == la) begin
					hit_at = i;
				end
			end
			if (hit_at >= 0) begin
				kind = 1;
				n_swap++;
				vc_line[hit_at] = l1_line[idx];
			end else begin
				kind = 2;
				n_refill++;
				if (l1_valid[idx]) begin
					vc_line[vc_ptr]  = l1_line[idx];
					vc_valid[vc_ptr] = 1'b1;
					vc_ptr = (vc_ptr + 1) % `FETCH_VC_ENTRIES;
				end
			end
			l1_valid[idx] = 1'b1;
			l1_line[idx]  = la;
		end
	endtask

	// memory answers a request after 1 to 6 cycles
	always @(negedge clk_i) begin
		if (mem_ready_i) begin
			mem_ready_i = 1'b0;
			mem_line_i  = '0;
		end else if (mem_req_o) begin
			if (mem_wait == 0) begin
				mem_rng  = xorshift(mem_rng);
				mem_wait = 1 + int'(mem_rng % 6);
			end
			mem_wait = mem_wait - 1;
			if (mem_wait == 0) begin
				mem_ready_i = 1'b1;
				mem_line_i  = mem_line(mem_addr_o);
			end
		end
	end

	// outputs are compared with the model before each edge, then the model steps
	always @(posedge clk_i) begin
		if (rst_ni) begin
			if (fresh) begin
				model_access(m_pc_bp[31:4], cls);
				phase = (cls == 0) ? PH_READY : PH_LOOKUP;
				fresh = 1'b0;
			end
			assert (stall_o == (phase != PH_READY))
				else mismatch("stall_o", 32'(stall_o), 32'(phase != PH_READY));
			assert (mem_req_o == (phase == PH_REFILL))
				else mismatch("mem_req_o", 32'(mem_req_o), 32'(phase == PH_REFILL));
			if (phase == PH_REFILL) begin
				assert (mem_addr_o == m_pc_bp[31:4])
					else mismatch("mem_addr_o", 32'(mem_addr_o), 32'(m_pc_bp[31:4]));
			end
			assert (pc_bp_o == m_pc_bp) else mismatch("pc_bp_o", pc_bp_o, m_pc_bp);
			assert (pc_d_o == m_pc_d) else mismatch("pc_d_o", pc_d_o, m_pc_d);
			assert (inst_d_o == m_inst_d) else mismatch("inst_d_o", inst_d_o, m_inst_d);
			assert (pc4_d_o == m_pc4_d) else mismatch("pc4_d_o", pc4_d_o, m_pc4_d);
			assert (hit_d_o == m_hit_d) else mismatch("hit_d_o", 32'(hit_d_o), 32'(m_hit_d));
			assert (acc_cnt_o == hit_cnt_o + miss_cnt_o)
				else mismatch("acc_cnt_o", acc_cnt_o, hit_cnt_o + miss_cnt_o);
			assert (acc_cnt_o == tally_acc) else mismatch("acc_cnt_o", acc_cnt_o, tally_acc);
			assert (hit_cnt_o == tally_hit) else mismatch("hit_cnt_o", hit_cnt_o, tally_hit);
			assert (miss_cnt_o == tally_miss) else mismatch("miss_cnt_o", miss_cnt_o, tally_miss);

			deliver = enable_i && (phase == PH_READY);
			if (enable_i && flush_i) begin
				m_pc_d   = '0;
				m_inst_d = '0;
				m_pc4_d  = '0;
				m_hit_d  = 1'b0;
			end else if (deliver) begin
				m_pc_d   = m_pc_bp;
				m_inst_d = m_pc_bp ^ INST_KEY;
				m_pc4_d  = m_pc_bp + 32'd4;
				m_hit_d  = bp_hit_i;
			end
			if (deliver) begin
				tally_acc++;
				if (cls == 0) begin
					tally_hit++;
				end else begin
					tally_miss++;
				end
				m_pc_bp = next_pc(wrong_predicted_i, bp_hit_i, m_pc_bp);
				fresh = 1'b1;
			end
			case (phase)
				PH_LOOKUP: phase = (cls == 1) ? PH_SWAP : PH_REFILL;
				PH_REFILL: phase = mem_ready_i ? PH_FILL : PH_REFILL;
				PH_FILL:   phase = PH_READY;
				PH_SWAP:   phase = PH_READY;
				default:   phase = PH_READY;
			endcase
		end
	end

	task automatic drive_inputs(input int mode, input fetch_pkg::word_t base);
		logic [31:0] r1, r2;
		logic [1:0]  sel;
		enable_i          = 1'b1;
		flush_i           = 1'b0;
		bp_hit_i          = 1'b0;
		wrong_predicted_i = 2'd0;
		sel               = pc_bp_o[9:8];
		case (mode)
			MODE_LOOP: begin
				if (pc_bp_o[31:4] != base[31:4]) begin
					wrong_predicted_i = 2'd1;
					mispredicted_pc_i = base;
				end else if (pc_bp_o[3:2] == 2'd3) begin
					wrong_predicted_i = 2'd2;
					alu_pc_i          = base;
				end
			end
			MODE_CONFLICT: begin
				// three lines on one index, two words each
				if (pc_bp_o[31:10] != base[31:10]) begin
					wrong_predicted_i = 2'd1;
					mispredicted_pc_i = base;
				end else if (pc_bp_o[3:2] == 2'd1) begin
					wrong_predicted_i = 2'd1;
					mispredicted_pc_i = (sel == 2'd2) ? base : {pc_bp_o[31:8] + 24'd1, 8'h00};
				end
			end
			MODE_RANDOM: begin
				stim_rng          = xorshift(stim_rng);
				r1                = stim_rng;
				stim_rng          = xorshift(stim_rng);
				r2                = stim_rng;
				enable_i          = (r1[1:0] != 2'd0);
				flush_i           = (r1[4:2] == 3'd0);
				bp_hit_i          = r1[5];
				wrong_predicted_i = (r1[7:6] == 2'd3) ? 2'd0 : r1[7:6];
				predicted_pc_i    = {22'h0, r2[9:2], 2'b00};
				mispredicted_pc_i = {19'h0, r2[20:10], 2'b00};
				alu_pc_i          = {20'h0, r2[31:24], 4'h0};
			end
			default: ;
		endcase
	endtask

	task automatic fetch_n(input int n, input int mode, input fetch_pkg::word_t base);
		int start;
		int cyc;
		start = tally_acc;
		cyc   = 0;
		while (tally_acc - start < n) begin
			if (cyc == n * 20 + 100) begin
				fail_with("timed out while fetching instructions");
			end
			drive_inputs(mode, base);
			@(negedge clk_i);
			cyc++;
		end
	endtask

	// miss with enable low, refill must finish while IF/ID holds
	task automatic hold_during_refill(input fetch_pkg::word_t target);
		int cyc;
		cyc = 0;
		while (pc_bp_o != target) begin
			if (cyc == 100) begin
				fail_with("timed out jumping to the refill target");
			end
			drive_inputs(MODE_SEQ, target);
			wrong_predicted_i = 2'd1;
			mispredicted_pc_i = target;
			@(negedge clk_i);
			cyc++;
		end
		enable_i          = 1'b0;
		wrong_predicted_i = 2'd0;
		cyc = 0;
		while (!mem_req_o) begin
			if (cyc == 10) begin
				fail_with("no memory request for the held miss");
			end
			@(negedge clk_i);
			cyc++;
		end
		cyc = 0;
		while (stall_o) begin
			if (cyc == 20) begin
				fail_with("refill did not complete with enable low");
			end
			@(negedge clk_i);
			cyc++;
		end
		repeat (3) @(negedge clk_i);
	endtask

	initial begin
		clk_i             = 1'b0;
		rst_ni            = 1'b0;
		enable_i          = 1'b0;
		flush_i           = 1'b0;
		bp_hit_i          = 1'b0;
		predicted_pc_i    = '0;
		mispredicted_pc_i = '0;
		alu_pc_i          = '0;
		wrong_predicted_i = 2'd0;
		mem_ready_i       = 1'b0;
		mem_line_i        = '0;
		mem_rng           = SEED;
		stim_rng          = SEED;
		mem_wait          = 0;
		for (int i = 0; i < `FETCH_L1_LINES; i++) begin
			l1_valid[i] = 1'b0;
			l1_line[i]  = '0;
		end
		for (int i = 0; i < `FETCH_VC_ENTRIES; i++) begin
			vc_valid[i] = 1'b0;
			vc_line[i]  = '0;
		end
		vc_ptr     = 0;
		m_pc_bp    = `FETCH_RESET_PC;
		m_pc_d     = '0;
		m_inst_d   = '0;
		m_pc4_d    = '0;
		m_hit_d    = 1'b0;
		fresh      = 1'b1;
		deliver    = 1'b0;
		cls        = 0;
		phase      = PH_READY;
		tally_acc  = 0;
		tally_hit  = 0;
		tally_miss = 0;
		n_swap     = 0;
		n_refill   = 0;

		repeat (4) @(negedge clk_i);
		rst_ni = 1'b1;
		assert (mem_req_o == 1'b0) else mismatch("mem_req_o", 32'(mem_req_o), 32'h0);
		assert (acc_cnt_o == 0) else mismatch("acc_cnt_o", acc_cnt_o, 32'h0);
		assert (hit_cnt_o == 0) else mismatch("hit_cnt_o", hit_cnt_o, 32'h0);
		assert (miss_cnt_o == 0) else mismatch("miss_cnt_o", miss_cnt_o, 32'h0);
		assert (pc_bp_o == `FETCH_RESET_PC) else mismatch("pc_bp_o", pc_bp_o, `FETCH_RESET_PC);
		assert (stall_o == 1'b1) else mismatch("stall_o", 32'(stall_o), 32'h1);

		fetch_n(40, MODE_SEQ, 32'h0);
		fetch_n(40, MODE_LOOP, 32'h0000_0400);
		fetch_n(60, MODE_CONFLICT, 32'h0000_1000);
		hold_during_refill(32'h0000_8000);
		fetch_n(300, MODE_RANDOM, 32'h0);

		assert (acc_cnt_o == tally_acc) else mismatch("acc_cnt_o", acc_cnt_o, tally_acc);
		assert (hit_cnt_o == tally_hit) else mismatch("hit_cnt_o", hit_cnt_o, tally_hit);
		assert (miss_cnt_o == tally_miss) else mismatch("miss_cnt_o", miss_cnt_o, tally_miss);
		if (n_swap > 0 && n_refill > 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			fail_with("run ended without both a victim swap and a memory refill");
		end
	end

endmodule

`default_nettype wire

/* victim_cache.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_defines.svh"

module victim_cache (
	input  logic     clk_i,
	input  logic     rst_ni,
	victim_if.victim vc,
	output logic     hit_o
);

	localparam int unsigned N     = `FETCH_VC_ENTRIES;
	localparam int unsigned PTR_W = $clog2(N);

	logic [N-1:0]          valid_q;
	fetch_pkg::line_addr_t tag_q  [N];
	fetch_pkg::line_t      data_q [N];
	logic [PTR_W-1:0]      fifo_ptr_q;

	logic [N-1:0]          match;
	logic [PTR_W-1:0]      hit_idx;
	logic [PTR_W-1:0]      wr_idx;

	// full address compare on every entry
	always_comb begin
		hit_idx = '0;
		for (int i = 0; i < N; i++) begin
			match[i] = valid_q[i] && (tag_q[i] == vc.probe_addr);
			if (match[i]) begin
				hit_idx = PTR_W'(i);
			end
		end
	end

	assign vc.probe_hit  = |match;
	assign vc.probe_line = data_q[hit_idx];
	assign hit_o         = vc.probe_hit;

	// a swap reuses the hit entry, anything else takes the FIFO slot
	// L1 always holds a valid line at the index of any entry here,
	// so a swap always comes with an eviction
	assign wr_idx = vc.probe_hit ? hit_idx : fifo_ptr_q;

	always_ff @(posedge clk_i) begin
		if (vc.evict_valid) begin
			tag_q[wr_idx]  <= vc.evict_addr;
			data_q[wr_idx] <= vc.evict_line;
		end
	end

	always_ff @(posedge clk_i, negedge rst_ni) begin
		if (!rst_ni) begin
			valid_q    <= '0;
			fifo_ptr_q <= '0;
		end else if (vc.evict_valid) begin
			valid_q[wr_idx] <= 1'b1;
			if (!vc.probe_hit) begin
				fifo_ptr_q <= fifo_ptr_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* victim_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface victim_if;

	// eviction from L1, one-cycle strobe
	logic                   evict_valid;
	fetch_pkg::line_addr_t  evict_addr;
	fetch_pkg::line_t       evict_line;

	// probe on L1 miss, answered combinationally
	fetch_pkg::line_addr_t  probe_addr;
	logic                   probe_hit;
	fetch_pkg::line_t       probe_line;

	modport l1 (
		output evict_valid, evict_addr, evict_line, probe_addr,
		input  probe_hit, probe_line
	);

	modport victim (
		input  evict_valid, evict_addr, evict_line, probe_addr,
		output probe_hit, probe_line
	);

endinterface

`default_nettype wire
